/* plic.f */
+incdir+source
source/plicPkg.sv
source/plicRegs.sv
source/plicGateway.sv
source/plicArbiter.sv
source/plicTop.sv
tests/plic_chk.sv
tests/plicMonitor.sv
tests/plicTb.sv

/* Makefile */
# Verilator build and run for the PLIC testbench

VERILATOR ?= verilator
TOP       ?= plicTb
FILELIST  ?= plic.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
# keep running past assertion errors so the closing line is printed
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tests/plicTb.sv */
////////////////////////////////////////////////////////////
// PLIC testbench
// AHB-Lite stimulus, source driving and run control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicTb;

  localparam int N = `PLIC_NUM_SRC;
  localparam int MAX_PRIO = (1 << `PLIC_PRIO_BITS) - 1;
  // tests take about 2000 cycles
  localparam int TIMEOUT_CYCLES = 6000;
  localparam logic [1:0] NONSEQ = 2'b10;

  logic                       HCLK;
  logic                       HRESETn;
  logic                       HSEL;
  logic [`PLIC_ADDR_BITS-1:0] HADDR;
  logic                       HWRITE;
  logic [1:0]                 HTRANS;
  logic                       HREADY;
  logic [31:0]                HWDATA;
  logic [31:0]                HRDATA;
  logic                       HREADYOUT;
  logic                       HRESP;
  logic [N:1]                 irqSources;
  logic                       ExtIntM;
  int                         testId;
  int                         cycleCount;

  plicTop u_dut (
    .HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR), .HWRITE(HWRITE),
    .HTRANS(HTRANS), .HREADY(HREADY), .HWDATA(HWDATA), .HRDATA(HRDATA),
    .HREADYOUT(HREADYOUT), .HRESP(HRESP), .irqSources(irqSources), .ExtIntM(ExtIntM)
  );

  plicMonitor u_mon (
    .HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR), .HWRITE(HWRITE),
    .HTRANS(HTRANS), .HREADY(HREADY), .HWDATA(HWDATA), .HRDATA(HRDATA),
    .irqSources(irqSources), .ExtIntM(ExtIntM), .testId(testId)
  );

  // 100 ns clock
  always #50 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // bus and source tasks
  ////////////////////////////////////////////////////////////

  task automatic busWrite(input int ofs, input logic [31:0] data);
    @(posedge HCLK);
    HSEL <= 1'b1;
    HADDR <= `PLIC_ADDR_BITS'(ofs);
    HWRITE <= 1'b1;
    HTRANS <= NONSEQ;
    // data phase
    @(posedge HCLK);
    HSEL <= 1'b0;
    HWRITE <= 1'b0;
    HTRANS <= 2'b00;
    HWDATA <= data;
  endtask

  task automatic busRead(input int ofs, output logic [31:0] data);
    @(posedge HCLK);
    HSEL <= 1'b1;
    HADDR <= `PLIC_ADDR_BITS'(ofs);
    HWRITE <= 1'b0;
    HTRANS <= NONSEQ;
    @(posedge HCLK);
    HSEL <= 1'b0;
    HTRANS <= 2'b00;
    // read data is settled by mid data phase
    @(negedge HCLK);
    data = HRDATA;
  endtask

  task automatic setSources(input logic [N:1] value);
    @(posedge HCLK);
    irqSources <= value;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge HCLK);
  endtask

  // claim and complete until the claim register returns 0
  task automatic drainAll();
    logic [31:0] cid;
    int          count;
    count = 0;
    busRead(`PLIC_OFS_CLAIM, cid);
    while (cid != 0 && count < 4 * N) begin
      busWrite(`PLIC_OFS_CLAIM, cid);
      count++;
      busRead(`PLIC_OFS_CLAIM, cid);
    end
  endtask

  task automatic randomPriorities();
    for (int i = 1; i <= N; i++) begin
      busWrite(`PLIC_OFS_PRIO + 4 * i, $urandom % (MAX_PRIO + 1));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd;
    int          errors;
    HCLK = 1'b0;
    HRESETn = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HWRITE = 1'b0;
    HTRANS = 2'b00;
    HREADY = 1'b1;
    HWDATA = '0;
    irqSources = '0;
    testId = 0;
    void'($urandom(32'hdbaf_aae0));
    repeat (16) @(posedge HCLK);
    HRESETn <= 1'b1;

    // register readback, full random words land masked
    testId <= 1;
    for (int i = 1; i <= N; i++) busWrite(`PLIC_OFS_PRIO + 4 * i, $urandom);
    busWrite(`PLIC_OFS_EN, $urandom);
    busWrite(`PLIC_OFS_THRESH, $urandom);
    for (int i = 1; i <= N; i++) busRead(`PLIC_OFS_PRIO + 4 * i, rd);
    busRead(`PLIC_OFS_EN, rd);
    busRead(`PLIC_OFS_THRESH, rd);
    setSources(N'($urandom));
    idleCycles(1);
    busRead(`PLIC_OFS_PEND, rd);
    setSources('0);

    // arbitration, priority 0 and disabled sources included
    testId <= 2;
    for (int r = 0; r < 12; r++) begin
      randomPriorities();
      busWrite(`PLIC_OFS_EN, $urandom);
      setSources(N'($urandom));
      idleCycles(2);
      busRead(`PLIC_OFS_CLAIM, rd);
      setSources('0);
      busWrite(`PLIC_OFS_CLAIM, rd);
    end

    // every threshold against a fixed pending set
    testId <= 3;
    randomPriorities();
    busWrite(`PLIC_OFS_EN, 32'hffff_ffff);
    setSources(N'($urandom) | N'(1));
    idleCycles(2);
    for (int t = 0; t <= MAX_PRIO; t++) begin
      busWrite(`PLIC_OFS_THRESH, 32'(t));
      idleCycles(3);
    end
    setSources('0);
    busWrite(`PLIC_OFS_THRESH, 32'h0);
    drainAll();

    // source 3 held high through claim and complete
    testId <= 4;
    busWrite(`PLIC_OFS_PRIO + 4 * 3, 32'd5);
    busWrite(`PLIC_OFS_EN, 32'h8);
    setSources(N'(1) << 2);
    idleCycles(2);
    busRead(`PLIC_OFS_PEND, rd);
    busRead(`PLIC_OFS_CLAIM, rd);
    idleCycles(4);
    busRead(`PLIC_OFS_PEND, rd);
    busWrite(`PLIC_OFS_CLAIM, 32'd3);
    idleCycles(2);
    busRead(`PLIC_OFS_PEND, rd);
    setSources('0);
    drainAll();

    // bursts of sources drained in priority then ID order
    testId <= 5;
    busWrite(`PLIC_OFS_EN, 32'hffff_ffff);
    for (int r = 0; r < 8; r++) begin
      randomPriorities();
      busWrite(`PLIC_OFS_THRESH, $urandom % 3);
      setSources(N'($urandom));
      idleCycles(2);
      setSources('0);
      drainAll();
    end

    testId <= 0;
    idleCycles(2);
    errors = u_mon.errCount + u_dut.u_chk.failCount;
    $display("checks: %0d  mismatches: %0d  assertion failures: %0d",
             u_mon.checkCount, u_mon.errCount, u_dut.u_chk.failCount);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("timeout: tests still running after %0d cycles", cycleCount);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* tests/plicMonitor.sv */
////////////////////////////////////////////////////////////
// PLIC monitor
// shadow model of registers, pending and in-progress state;
// compares read data and the interrupt line
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicMonitor import plicPkg::*; (
  input logic                       HCLK,
  input logic                       HRESETn,
  input logic                       HSEL,
  input logic [`PLIC_ADDR_BITS-1:0] HADDR,
  input logic                       HWRITE,
  input logic [1:0]                 HTRANS,
  input logic                       HREADY,
  input logic [31:0]                HWDATA,
  input logic [31:0]                HRDATA,
  input logic [`PLIC_NUM_SRC:1]     irqSources,
  input logic                       ExtIntM,
  input int                         testId
);

  localparam int N = `PLIC_NUM_SRC;

  int errCount = 0;
  int checkCount = 0;

  // shadow state
  prioVec_t                   prio;
  logic [N:1]                 en;
  logic [N:1]                 pend;
  logic [N:1]                 inProg;
  logic [`PLIC_PRIO_BITS-1:0] thr;
  // outstanding data phases
  logic                       rdPending;
  logic [31:0]                expRd;
  logic                       wrPending;
  int                         wrOfs;

  function automatic string testName(input int id);
    case (id)
      1: return "readback";
      2: return "arbitration";
      3: return "threshold";
      4: return "claimComplete";
      5: return "multiSource";
      default: return "idle";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // best enabled pending source, strict compare keeps the lowest ID
  function automatic void refClaim(input prioVec_t p, input logic [N:1] e,
                                   input logic [N:1] pd, output srcId_t id,
                                   output int best);
    id = '0;
    best = 0;
    for (int i = 1; i <= N; i++) begin
      if (e[i] && pd[i] && int'(p[i]) > best) begin
        best = int'(p[i]);
        id = srcId_t'(i);
      end
    end
  endfunction

  // one bit per valid source ID, nothing for 0 or out of range
  function automatic logic [N:1] idBit(input srcId_t id);
    logic [N:1] m;
    m = '0;
    if (id != 0 && int'(id) <= N) m = N'(1) << (int'(id) - 1);
    return m;
  endfunction

  // expected read data at a word offset
  function automatic logic [31:0] regValue(input int ofs, input srcId_t cid);
    logic [31:0] v;
    v = '0;
    if (ofs == `PLIC_OFS_PEND) v[N:1] = pend;
    else if (ofs == `PLIC_OFS_EN) v[N:1] = en;
    else if (ofs == `PLIC_OFS_THRESH) v = 32'(thr);
    else if (ofs == `PLIC_OFS_CLAIM) v = 32'(cid);
    else begin
      for (int i = 1; i <= N; i++) begin
        if (ofs == `PLIC_OFS_PRIO + 4 * i) v = 32'(prio[i]);
      end
    end
    return v;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expv,
                            input logic [31:0] act);
    checkCount++;
    if (act !== expv) begin
      errCount++;
      $display("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
               testName(testId), what, expv, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare and advance, once per cycle
  ////////////////////////////////////////////////////////////

  always @(posedge HCLK or negedge HRESETn) begin : compare
    srcId_t     cid;
    int         best;
    int         ofs;
    logic [N:1] claimMask;
    logic [N:1] doneMask;
    if (!HRESETn) begin
      prio = '0;
      en = '0;
      pend = '0;
      inProg = '0;
      thr = '0;
      rdPending = 1'b0;
      wrPending = 1'b0;
    end else begin
      refClaim(prio, en, pend, cid, best);
      // values seen here belong to the cycle that just ended
      if (rdPending) checkValue("HRDATA", expRd, HRDATA);
      checkValue("ExtIntM", {31'b0, best > int'(thr)}, {31'b0, ExtIntM});
      claimMask = '0;
      doneMask = '0;
      // address phase, reads see the state before any write lands
      ofs = int'(HADDR[21:2]) << 2;
      rdPending = 1'b0;
      if (HSEL && HREADY && HTRANS != 2'b00 && !HWRITE) begin
        rdPending = 1'b1;
        expRd = regValue(ofs, cid);
        if (ofs == `PLIC_OFS_CLAIM) claimMask = idBit(cid);
      end
      // write data phase
      if (wrPending) begin
        if (wrOfs == `PLIC_OFS_CLAIM) doneMask = idBit(HWDATA[4:0]);
        else if (wrOfs == `PLIC_OFS_EN) en = HWDATA[N:1];
        else if (wrOfs == `PLIC_OFS_THRESH) thr = HWDATA[`PLIC_PRIO_BITS-1:0];
        else begin
          for (int i = 1; i <= N; i++) begin
            if (wrOfs == `PLIC_OFS_PRIO + 4 * i) prio[i] = HWDATA[`PLIC_PRIO_BITS-1:0];
          end
        end
      end
      wrPending = HSEL && HREADY && HTRANS != 2'b00 && HWRITE;
      wrOfs = ofs;
      // level sensitive gateway rules, one source at a time
      for (int i = 1; i <= N; i++) begin
        if (claimMask[i]) begin
          // claimed source leaves pending and goes into service
          pend[i] = 1'b0;
          inProg[i] = 1'b1;
        end else begin
          // high and not in service, pending until claimed
          if (irqSources[i] && !inProg[i]) pend[i] = 1'b1;
          if (doneMask[i]) inProg[i] = 1'b0;
        end
      end
    end
  end

endmodule

/* tests/plic_chk.sv */
////////////////////////////////////////////////////////////
// PLIC bus and interrupt checker
// concurrent assertions bound onto the PLIC top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module plicChk (
  input logic        HCLK,
  input logic        HRESETn,
  input logic        HSEL,
  input logic [1:0]  HTRANS,
  input logic        HREADY,
  input logic [31:0] HRDATA,
  input logic        HREADYOUT,
  input logic        HRESP,
  input logic        ExtIntM
);

  int   failCount = 0;
  logic dataPhase;

  // any accepted transfer is followed by its data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dataPhase <= 1'b0;
    end else begin
      dataPhase <= HSEL & HREADY & (HTRANS != 2'b00);
    end
  end

  // zero wait state slave
  readyHigh: assert property (@(posedge HCLK) HREADYOUT == 1'b1)
    else begin
      failCount++;
      $error("HREADYOUT went low");
    end

  // never an error response
  respOkay: assert property (@(posedge HCLK) HRESP == 1'b0)
    else begin
      failCount++;
      $error("HRESP is not OKAY");
    end

  intQuietInReset: assert property (@(posedge HCLK) !HRESETn |-> !ExtIntM)
    else begin
      failCount++;
      $error("ExtIntM high during reset");
    end

  rdataKnown: assert property (@(posedge HCLK) disable iff (!HRESETn)
                               dataPhase |-> !$isunknown(HRDATA))
    else begin
      failCount++;
      $error("HRDATA unknown in a data phase");
    end

endmodule

bind plicTop plicChk u_chk (
  .HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HTRANS(HTRANS), .HREADY(HREADY),
  .HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP), .ExtIntM(ExtIntM)
);

/* source/plicTop.sv */
////////////////////////////////////////////////////////////
// PLIC top level
// AHB-Lite slave, gateway and arbiter for a single hart
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicTop import plicPkg::*; (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HSEL,
  input  logic [`PLIC_ADDR_BITS-1:0]  HADDR,
  input  logic                        HWRITE,
  input  logic [1:0]                  HTRANS,
  input  logic                        HREADY,
  input  logic [31:0]                 HWDATA,
  output logic [31:0]                 HRDATA,
  output logic                        HREADYOUT,
  output logic                        HRESP,
  input  logic [`PLIC_NUM_SRC:1]      irqSources,
  output logic                        ExtIntM
);

  ahbReq_t                    busReq;
  claimEvt_t                  claimEvt;
  prioVec_t                   priorities;
  logic [`PLIC_NUM_SRC:1]     enables;
  logic [`PLIC_NUM_SRC:1]     pending;
  logic [`PLIC_PRIO_BITS-1:0] threshold;
  srcId_t                     claimId;

  // address phase inputs travel as one bundle
  assign busReq = '{sel: HSEL, addr: HADDR, write: HWRITE, trans: HTRANS, ready: HREADY};

  plicRegs u_regs (
    .HCLK(HCLK), .HRESETn(HRESETn), .bus(busReq), .HWDATA(HWDATA),
    .pending(pending), .claimId(claimId), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT),
    .HRESP(HRESP), .priorities(priorities), .enables(enables),
    .threshold(threshold), .claimEvt(claimEvt)
  );

  plicGateway u_gateway (
    .HCLK(HCLK), .HRESETn(HRESETn), .irqSources(irqSources),
    .claimEvt(claimEvt), .claimId(claimId), .pending(pending)
  );

  plicArbiter u_arbiter (
    .priorities(priorities), .enables(enables), .pending(pending),
    .threshold(threshold), .claimId(claimId), .ExtIntM(ExtIntM)
  );

endmodule

/* source/plicArbiter.sv */
////////////////////////////////////////////////////////////
// PLIC arbiter
// highest enabled pending priority, lowest ID on a tie,
// compared against the global threshold
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicArbiter import plicPkg::*; (
  input  prioVec_t                   priorities,
  input  logic [`PLIC_NUM_SRC:1]     enables,
  input  logic [`PLIC_NUM_SRC:1]     pending,
  input  logic [`PLIC_PRIO_BITS-1:0] threshold,
  output srcId_t                     claimId,
  output logic                       ExtIntM
);

  // number of priority levels, level 0 never competes
  localparam int NUM_LVL = 1 << `PLIC_PRIO_BITS;

  // candidates grouped by priority level
  logic [NUM_LVL-1:0][`PLIC_NUM_SRC:1] lvlReq;
  logic [NUM_LVL-1:1]                  lvlAny;
  logic [`PLIC_PRIO_BITS-1:0]          maxLvl;
  logic [`PLIC_NUM_SRC:1]              winners;

  ////////////////////////////////////////////////////////////
  // group by level
  ////////////////////////////////////////////////////////////

  always_comb begin
    lvlReq = '0;
    // level 0 row stays empty
    for (int lvl = 1; lvl < NUM_LVL; lvl++) begin
      for (int i = 1; i <= `PLIC_NUM_SRC; i++) begin
        lvlReq[lvl][i] = enables[i] & pending[i] &
                         (priorities[i] == `PLIC_PRIO_BITS'(lvl));
      end
    end
  end

  always_comb begin
    for (int lvl = 1; lvl < NUM_LVL; lvl++) begin
      lvlAny[lvl] = |lvlReq[lvl];
    end
  end

  ////////////////////////////////////////////////////////////
  // highest nonempty level
  ////////////////////////////////////////////////////////////

  always_comb begin
    maxLvl = '0;
    // ascending scan, the last hit is the highest
    for (int lvl = 1; lvl < NUM_LVL; lvl++) begin
      if (lvlAny[lvl]) maxLvl = `PLIC_PRIO_BITS'(lvl);
    end
  end

  // maxLvl of 0 selects the empty row
  assign winners = lvlReq[maxLvl];

  ////////////////////////////////////////////////////////////
  // lowest ID at that level
  ////////////////////////////////////////////////////////////

  always_comb begin
    claimId = '0;
    // descending scan leaves the lowest set index
    for (int i = `PLIC_NUM_SRC; i >= 1; i--) begin
      if (winners[i]) claimId = srcId_t'(i);
    end
  end

  // strictly above threshold, so threshold 7 masks everything
  assign ExtIntM = (maxLvl > threshold);

endmodule

/* source/plicGateway.sv */
////////////////////////////////////////////////////////////
// PLIC gateway
// level sensitive pending and in-progress state per source
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicGateway import plicPkg::*; (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic [`PLIC_NUM_SRC:1] irqSources,
  input  claimEvt_t              claimEvt,
  input  srcId_t                 claimId,
  output logic [`PLIC_NUM_SRC:1] pending
);

  logic [`PLIC_NUM_SRC:1] inProgress;
  logic [`PLIC_NUM_SRC:1] claimMask;
  logic [`PLIC_NUM_SRC:1] completeMask;

  // one-hot mask for a source ID, ID 0 gives an empty mask
  function automatic logic [`PLIC_NUM_SRC:1] idMask(input srcId_t id);
    logic [`PLIC_NUM_SRC:1] m;
    m = '0;
    for (int i = 1; i <= `PLIC_NUM_SRC; i++) begin
      m[i] = (id == srcId_t'(i));
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////
  // claim and complete masks
  ////////////////////////////////////////////////////////////

  // claimed source leaves pending and enters in-progress
  assign claimMask    = claimEvt.claimRead ? idMask(claimId) : '0;
  // completed source leaves in-progress
  assign completeMask = claimEvt.completeWrite ? idMask(claimEvt.completeId) : '0;

  ////////////////////////////////////////////////////////////
  // state update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pending    <= '0;
      inProgress <= '0;
    end else begin
      // high source not in service raises pending
      // pending holds until the claim
      pending    <= (pending | (irqSources & ~inProgress)) & ~claimMask;
      // a claim in the same cycle wins over a stray complete
      inProgress <= (inProgress & ~completeMask) | claimMask;
    end
  end

  // still-high source re-pends the cycle after in-progress drops
  // since the pending update looks at registered inProgress

endmodule

/* source/plicRegs.sv */
////////////////////////////////////////////////////////////
// PLIC register block
// AHB-Lite slave holding priority, enable and threshold and
// producing the claim and complete strobes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "plic_macros.svh"

module plicRegs import plicPkg::*; (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  ahbReq_t                   bus,
  input  logic [31:0]               HWDATA,
  input  logic [`PLIC_NUM_SRC:1]    pending,
  input  srcId_t                    claimId,
  output logic [31:0]               HRDATA,
  output logic                      HREADYOUT,
  output logic                      HRESP,
  output prioVec_t                  priorities,
  output logic [`PLIC_NUM_SRC:1]    enables,
  output logic [`PLIC_PRIO_BITS-1:0] threshold,
  output claimEvt_t                 claimEvt
);

  // low address bits that select a register inside the window
  localparam int OFS_BITS = 22;

  localparam logic [OFS_BITS-1:0] OFS_PEND   = OFS_BITS'(`PLIC_OFS_PEND);
  localparam logic [OFS_BITS-1:0] OFS_EN     = OFS_BITS'(`PLIC_OFS_EN);
  localparam logic [OFS_BITS-1:0] OFS_THRESH = OFS_BITS'(`PLIC_OFS_THRESH);
  localparam logic [OFS_BITS-1:0] OFS_CLAIM  = OFS_BITS'(`PLIC_OFS_CLAIM);

  logic                addrPhase;
  logic                readPhase;
  logic [OFS_BITS-1:0] ofs;
  logic [OFS_BITS-1:0] wrOfs;
  logic                wrValid;
  logic [31:0]         rdData;

  // priority register offset for source i
  function automatic logic [OFS_BITS-1:0] prioOfs(input int i);
    return OFS_BITS'(`PLIC_OFS_PRIO + 4 * i);
  endfunction

  ////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////

  // nonidle transfer that the previous slave has let through
  assign addrPhase = bus.sel & bus.ready & (bus.trans != 2'b00);
  assign readPhase = addrPhase & ~bus.write;
  // word aligned, byte lanes ignored
  assign ofs = {bus.addr[OFS_BITS-1:2], 2'b00};

  // zero wait states, always OKAY
  assign HREADYOUT = 1'b1;
  assign HRESP     = 1'b0;

  // write data arrives one cycle later, hold the target
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wrValid <= 1'b0;
    end else begin
      wrValid <= addrPhase & bus.write;
    end
  end

  always_ff @(posedge HCLK) begin
    wrOfs <= ofs;
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdData = '0;
    if (ofs == OFS_PEND) begin
      // bit i is source i, bit 0 stays zero
      rdData[`PLIC_NUM_SRC:1] = pending;
    end else if (ofs == OFS_EN) begin
      rdData[`PLIC_NUM_SRC:1] = enables;
    end else if (ofs == OFS_THRESH) begin
      rdData[`PLIC_PRIO_BITS-1:0] = threshold;
    end else if (ofs == OFS_CLAIM) begin
      rdData[$bits(srcId_t)-1:0] = claimId;
    end else begin
      for (int i = 1; i <= `PLIC_NUM_SRC; i++) begin
        if (ofs == prioOfs(i)) rdData[`PLIC_PRIO_BITS-1:0] = priorities[i];
      end
    end
  end

  // captured in the address phase, driven in the data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HRDATA <= '0;
    end else begin
      HRDATA <= readPhase ? rdData : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      priorities <= '0;
      enables    <= '0;
      threshold  <= '0;
    end else if (wrValid) begin
      for (int i = 1; i <= `PLIC_NUM_SRC; i++) begin
        if (wrOfs == prioOfs(i)) priorities[i] <= HWDATA[`PLIC_PRIO_BITS-1:0];
      end
      if (wrOfs == OFS_EN) enables <= HWDATA[`PLIC_NUM_SRC:1];
      if (wrOfs == OFS_THRESH) threshold <= HWDATA[`PLIC_PRIO_BITS-1:0];
    end
  end

  // claim on read only, complete on write only
  assign claimEvt.claimRead     = readPhase & (ofs == OFS_CLAIM);
  assign claimEvt.completeWrite = wrValid & (wrOfs == OFS_CLAIM);
  assign claimEvt.completeId    = HWDATA[$bits(srcId_t)-1:0];

endmodule

/* source/plicPkg.sv */
////////////////////////////////////////////////////////////
// PLIC shared types
// bus request bundle, claim/complete strobes, source IDs
////////////////////////////////////////////////////////////
`include "plic_macros.svh"

package plicPkg;

  ////////////////////////////////////////////////////////////
  // source identifiers
  ////////////////////////////////////////////////////////////

  // source number, 0 means no source
  typedef logic [4:0] srcId_t;

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  // AHB-Lite address phase signals, sampled together
  typedef struct packed {
    logic                        sel;
    logic [`PLIC_ADDR_BITS-1:0]  addr;
    logic                        write;
    logic [1:0]                  trans;
    logic                        ready;
  } ahbReq_t;

  ////////////////////////////////////////////////////////////
  // register block to gateway
  ////////////////////////////////////////////////////////////

  // claimRead pulses in the address phase of a claim read
  // completeWrite pulses in the data phase of a complete write
  typedef struct packed {
    logic   claimRead;
    logic   completeWrite;
    srcId_t completeId;
  } claimEvt_t;

  // all source priorities, entry i belongs to source i
  typedef logic [`PLIC_NUM_SRC:1][`PLIC_PRIO_BITS-1:0] prioVec_t;

endpackage

/* source/plic_macros.svh */
////////////////////////////////////////////////////////////
// PLIC build parameters
// source count, priority width, bus address width and the
// word offsets of the register map
////////////////////////////////////////////////////////////
`ifndef PLIC_MACROS_SVH
`define PLIC_MACROS_SVH

// number of interrupt sources, 1 to 31 (source 0 is reserved)
`define PLIC_NUM_SRC 8

// width of a priority and of the threshold
`define PLIC_PRIO_BITS 3

// HADDR width seen by the slave
`define PLIC_ADDR_BITS 28

// register offsets inside the decoded window
// priority of source i lives at PLIC_OFS_PRIO + 4*i
`define PLIC_OFS_PRIO 'h000000
`define PLIC_OFS_PEND 'h001000
`define PLIC_OFS_EN 'h002000
`define PLIC_OFS_THRESH 'h200000
`define PLIC_OFS_CLAIM 'h200004

`endif
